//--- src/vdg_pkg.sv
`default_nettype none

package vdg_pkg;

   // basic widths
   typedef logic [7:0]  char_code_t;   // display byte / glyph row byte
   typedef logic [10:0] dsp_addr_t;    // 2k display entries
   typedef logic [11:0] cg_addr_t;     // code x 16 + glyph row
   typedef logic [6:0]  hchar_t;       // 0-99 per line
   typedef logic [4:0]  vrow_t;        // character row
   typedef logic [4:0]  vline_t;       // line within a row
   typedef logic [2:0]  pix_t;         // pixel within a character
   typedef logic [15:0] axil_addr_t;
   typedef logic [31:0] axil_data_t;

   // raster position, cols80 latched at frame start
   typedef struct packed {
      hchar_t hchar;
      pix_t   pix;
      vrow_t  vrow;
      vline_t vline;
      logic   cols80;
   } raster_pos_t;

   // mode register, cols80 is bit 0
   typedef struct packed {
      logic alt_set;      // reserved
      logic double_wide;  // 32/40 columns
      logic inverse_en;
      logic cols80;       // 80x24 when set
   } mode_reg_t;

   // horizontal geometry
   localparam hchar_t     H_TOTAL   = 7'd100;
   localparam hchar_t     H_ACTIVE  = 7'd80;
   localparam logic [9:0] HSYNC_ON  = {7'd82, 3'd2};  // {char, pix}
   localparam logic [9:0] HSYNC_OFF = {7'd94, 3'd2};

   // vertical geometry, {row, line} pairs
   localparam logic [9:0] FRAME_END_64 = {5'd21, 5'd20};
   localparam logic [9:0] FRAME_END_80 = {5'd26, 5'd4};
   localparam vline_t     ROW_LINES_64 = 5'd24;  // 12-row cells, doubled
   localparam vline_t     ROW_LINES_80 = 5'd20;  // 10-row cells, doubled
   localparam vrow_t      V_ACTIVE_64  = 5'd20;
   localparam vrow_t      V_ACTIVE_80  = 5'd24;
   localparam vrow_t      VSYNC_ROW_64 = 5'd20;
   localparam vrow_t      VSYNC_ROW_80 = 5'd24;
   localparam vline_t     VSYNC_LINE_ON   = 5'd9;
   localparam vline_t     VSYNC_LINE_LAST = 5'd10;

   // centring of 64x16 inside the 80x24 raster
   localparam hchar_t OFFSET_X_64 = 7'd8;
   localparam vrow_t  OFFSET_Y_64 = 5'd2;
   localparam hchar_t COLS_64     = 7'd64;
   localparam vrow_t  ROWS_64     = 5'd16;

   // host address map, bits 15:14
   localparam logic [1:0] REGION_DSP  = 2'd0;  // index from 12:2
   localparam logic [1:0] REGION_CG   = 2'd1;  // index from 13:2
   localparam logic [1:0] REGION_MODE = 2'd2;

endpackage

`default_nettype wire

//--- src/vdg_host_regs.sv
`timescale 1ns/1ps
`default_nettype none

module vdg_host_regs (
   input  wire logic                vga_clk,
   input  wire logic                rst,
   // AXI4-Lite write
   input  wire logic                awvalid,
   output logic                     awready,
   input  wire vdg_pkg::axil_addr_t awaddr,
   input  wire logic                wvalid,
   output logic                     wready,
   input  wire vdg_pkg::axil_data_t wdata,
   input  wire logic [3:0]          wstrb,
   output logic                     bvalid,
   input  wire logic                bready,
   output logic [1:0]               bresp,
   // AXI4-Lite read
   input  wire logic                arvalid,
   output logic                     arready,
   input  wire vdg_pkg::axil_addr_t araddr,
   output logic                     rvalid,
   input  wire logic                rready,
   output vdg_pkg::axil_data_t      rdata,
   output logic [1:0]               rresp,
   // mode and RAM host ports
   output vdg_pkg::mode_reg_t       mode,
   output logic                     dsp_en,
   output logic                     dsp_we,
   output vdg_pkg::dsp_addr_t       dsp_idx,
   output vdg_pkg::char_code_t      dsp_wdata,
   input  wire vdg_pkg::char_code_t dsp_rdata,
   output logic                     cg_en,
   output logic                     cg_we,
   output vdg_pkg::cg_addr_t        cg_idx,
   output vdg_pkg::char_code_t      cg_wdata
);
   import vdg_pkg::*;

   typedef enum logic [1:0] {idle, wr_resp, rd_wait, rd_resp} host_state_t;

   host_state_t state_q;
   logic        wr_fire;       // aw and w handshake this cycle
   logic        wr_ok;         // lane 0 actually written
   logic        rd_fire;       // ar handshake this cycle
   logic [1:0]  wr_region;
   logic [1:0]  rd_region_q;   // region held across the read

   assign wr_region = awaddr[15:14];
   assign wr_fire   = (state_q == idle) & awready & awvalid & wready & wvalid;
   assign wr_ok     = wr_fire & wstrb[0];  // byte registers, lane 0 only
   assign rd_fire   = (state_q == idle) & arready & arvalid;

   assign bresp = 2'b00;  // always OKAY
   assign rresp = 2'b00;

   // display RAM host port shared by writes and reads
   assign dsp_en    = (wr_ok & (wr_region == REGION_DSP)) |
                      (rd_fire & (araddr[15:14] == REGION_DSP));
   assign dsp_we    = wr_ok & (wr_region == REGION_DSP);
   assign dsp_idx   = wr_fire ? awaddr[12:2] : araddr[12:2];
   assign dsp_wdata = wdata[7:0];

   // char gen is write only from the host side
   assign cg_en    = wr_ok & (wr_region == REGION_CG);
   assign cg_we    = wr_ok & (wr_region == REGION_CG);
   assign cg_idx   = awaddr[13:2];
   assign cg_wdata = wdata[7:0];

   always_ff @(posedge vga_clk)
   begin
      if (rst)
      begin
         state_q     <= idle;
         awready     <= 1'b0;
         wready      <= 1'b0;
         arready     <= 1'b0;
         bvalid      <= 1'b0;
         rvalid      <= 1'b0;
         mode        <= '0;     // 64x16, no inverse
         rd_region_q <= REGION_DSP;
      end
      else
      begin
         case (state_q)
            idle:
            begin
               if (wr_fire)
               begin
                  awready <= 1'b0;
                  wready  <= 1'b0;
                  bvalid  <= 1'b1;        // response with the update
                  state_q <= wr_resp;
                  if (wr_ok && (wr_region == REGION_MODE))
                     mode <= mode_reg_t'(wdata[3:0]);
               end
               else if (rd_fire)
               begin
                  arready     <= 1'b0;
                  rd_region_q <= araddr[15:14];
                  state_q     <= rd_wait;  // RAM read in flight
               end
               else if (!awready && !arready)
               begin
                  if (awvalid && wvalid)   // writes win a tie
                  begin
                     awready <= 1'b1;
                     wready  <= 1'b1;
                  end
                  else if (arvalid)
                     arready <= 1'b1;
               end
            end
            wr_resp:
            begin
               if (bready)
               begin
                  bvalid  <= 1'b0;
                  state_q <= idle;
               end
            end
            rd_wait:
            begin
               rvalid  <= 1'b1;
               state_q <= rd_resp;
            end
            rd_resp:
            begin
               if (rready)
               begin
                  rvalid  <= 1'b0;
                  state_q <= idle;
               end
            end
            default: state_q <= idle;
         endcase
      end
   end

   // read data captured once the RAM output is valid
   always_ff @(posedge vga_clk)
   begin
      if (state_q == rd_wait)
      begin
         case (rd_region_q)
            REGION_DSP:  rdata <= {24'd0, dsp_rdata};
            REGION_MODE: rdata <= {28'd0, mode};
            default:     rdata <= '0;  // char gen reads as zero
         endcase
      end
   end

   // responses held under back-pressure
   assert property (@(posedge vga_clk) disable iff (rst)
      bvalid && !bready |=> bvalid);
   assert property (@(posedge vga_clk) disable iff (rst)
      rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

`default_nettype wire

//--- src/vdg_raster_timing.sv
`timescale 1ns/1ps
`default_nettype none

module vdg_raster_timing (
   input  wire logic               vga_clk,
   input  wire logic               rst,
   input  wire vdg_pkg::mode_reg_t mode,
   output vdg_pkg::raster_pos_t    pos,
   output logic                    active,
   output logic                    h_sync,
   output logic                    v_sync
);
   import vdg_pkg::*;

   pix_t       pix_q;
   hchar_t     hchar_q;
   vrow_t      vrow_q;
   vline_t     vline_q;
   logic       cols80_q;     // mode in force for this frame
   vline_t     row_lines;
   vrow_t      vsync_row;
   vrow_t      rows_active;
   logic [9:0] frame_last;
   logic [9:0] hpos;
   logic       frame_end;
   logic       row_end;

   // geometry of the latched mode
   assign row_lines   = cols80_q ? ROW_LINES_80 : ROW_LINES_64;
   assign vsync_row   = cols80_q ? VSYNC_ROW_80 : VSYNC_ROW_64;
   assign rows_active = cols80_q ? V_ACTIVE_80  : V_ACTIVE_64;
   assign frame_last  = cols80_q ? FRAME_END_80 : FRAME_END_64;

   assign frame_end = ({vrow_q, vline_q} == frame_last);
   assign row_end   = (vline_q == row_lines - 5'd1);
   assign hpos      = {hchar_q, pix_q};

   assign pos    = '{hchar: hchar_q, pix: pix_q, vrow: vrow_q, vline: vline_q,
                     cols80: cols80_q};
   assign active = (hchar_q < H_ACTIVE) && (vrow_q < rows_active);

   always_ff @(posedge vga_clk)
   begin
      if (rst)                     // counters start here
      begin
         pix_q    <= '0;
         hchar_q  <= '0;
         vrow_q   <= '0;
         vline_q  <= '0;
         cols80_q <= 1'b0;
      end
      else
      begin
         pix_q <= pix_q + 3'd1;    // wraps every character
         if (pix_q == 3'd7)
         begin
            if (hchar_q == H_TOTAL - 7'd1)
            begin
               hchar_q <= '0;
               if (frame_end)
               begin
                  vrow_q   <= '0;
                  vline_q  <= '0;
                  cols80_q <= mode.cols80;  // new mode only here
               end
               else if (row_end)
               begin
                  vline_q <= '0;
                  vrow_q  <= vrow_q + 5'd1;
               end
               else
                  vline_q <= vline_q + 5'd1;
            end
            else
               hchar_q <= hchar_q + 7'd1;
         end
      end
   end

   // syncs one cycle behind the counters
   always_ff @(posedge vga_clk)
   begin
      if (rst)
      begin
         h_sync <= 1'b0;
         v_sync <= 1'b0;
      end
      else
      begin
         h_sync <= (hpos >= HSYNC_ON) && (hpos < HSYNC_OFF);  // 96 clocks
         v_sync <= (vrow_q == vsync_row) &&
                   (vline_q >= VSYNC_LINE_ON) && (vline_q <= VSYNC_LINE_LAST);
      end
   end

   assert property (@(posedge vga_clk) disable iff (rst) hchar_q < H_TOTAL);
   // holds only if the mode never switches inside a frame
   assert property (@(posedge vga_clk) disable iff (rst) vline_q < row_lines);

endmodule

`default_nettype wire

//--- src/vdg_dual_port_ram.sv
`timescale 1ns/1ps
`default_nettype none

module vdg_dual_port_ram #(
   parameter int DEPTH  = 2048,
   parameter int ADDR_W = $clog2(DEPTH)
) (
   input  wire logic                vga_clk,
   // host port
   input  wire logic                a_en,
   input  wire logic                a_we,
   input  wire logic [ADDR_W-1:0]   a_idx,
   input  wire vdg_pkg::char_code_t a_wdata,
   output vdg_pkg::char_code_t      a_rdata,
   // video port, read only
   input  wire logic                b_en,
   input  wire logic [ADDR_W-1:0]   b_idx,
   output vdg_pkg::char_code_t      b_rdata
);
   import vdg_pkg::*;

   char_code_t mem [DEPTH];  // block RAM

   always_ff @(posedge vga_clk)
   begin
      if (a_en)
      begin
         if (a_we)
            mem[a_idx] <= a_wdata;
         a_rdata <= mem[a_idx];  // read old data on a write
      end
   end

   always_ff @(posedge vga_clk)
   begin
      if (b_en)
         b_rdata <= mem[b_idx];
   end

endmodule

`default_nettype wire

//--- src/vdg_char_pipeline.sv
`timescale 1ns/1ps
`default_nettype none

module vdg_char_pipeline (
   input  wire logic                 vga_clk,
   input  wire logic                 rst,
   input  wire vdg_pkg::raster_pos_t pos,
   input  wire logic                 active,
   input  wire vdg_pkg::mode_reg_t   mode,
   output vdg_pkg::dsp_addr_t        dsp_idx,
   input  wire vdg_pkg::char_code_t  dsp_data,
   output vdg_pkg::cg_addr_t         cg_idx,
   input  wire vdg_pkg::char_code_t  cg_data,
   output logic                      pixel_data
);
   import vdg_pkg::*;

   hchar_t     col_64;      // column inside the 64x16 window
   vrow_t      row_64;
   logic       in_window;
   logic       slot_load;   // this slot carries a character
   logic       load_pix;    // shift register load point
   logic [3:0] grow;        // glyph row, line halved
   char_code_t code_q;      // display byte of the current slot
   char_code_t glyph;
   logic       blk_sel;
   logic       inv_sel;
   logic [7:0] shift_q;

   assign col_64 = pos.hchar - OFFSET_X_64;  // wraps high outside
   assign row_64 = pos.vrow - OFFSET_Y_64;
   assign in_window = pos.cols80 | ((col_64 < COLS_64) && (row_64 < ROWS_64));

   // double wide uses even slots only, offset 8 keeps parity
   assign slot_load = active & in_window & (~mode.double_wide | ~pos.hchar[0]);
   assign load_pix  = (pos.pix == 3'd4) & (~mode.double_wide | ~pos.hchar[0]);
   assign grow      = pos.vline[4:1];  // each glyph row on two lines

   // display fetch, read at pix 0
   always_comb
   begin
      if (pos.cols80)
         dsp_idx = dsp_addr_t'(pos.vrow) * dsp_addr_t'(80) + dsp_addr_t'(pos.hchar);
      else
         dsp_idx = dsp_addr_t'({row_64[3:0], col_64[5:0]});  // 64 x row + col
   end

   // code captured once the fetch returns
   always_ff @(posedge vga_clk)
   begin
      if ((pos.pix == 3'd1) && slot_load)
         code_q <= dsp_data;
   end

   // glyph lookup at pix 2, bit 7 dropped under inverse video
   assign cg_idx = {code_q[7] & ~mode.inverse_en, code_q[6:0], grow};

   assign blk_sel = (code_q[7:6] == 2'b10) & ~mode.inverse_en;
   assign inv_sel = code_q[7] & mode.inverse_en;

   always_comb
   begin
      if (blk_sel)
      begin
         // 2x3 cells, left half from the even bit
         case (grow[3:2])
            2'd0:    glyph = {{4{code_q[0]}}, {4{code_q[1]}}};
            2'd1:    glyph = {{4{code_q[2]}}, {4{code_q[3]}}};
            2'd2:    glyph = {{4{code_q[4]}}, {4{code_q[5]}}};
            default: glyph = 8'h00;
         endcase
      end
      else
         glyph = (grow[3] ? 8'h00 : cg_data) ^ {8{inv_sel}};  // rows 8+ blank
   end

   // pixel shifter, msb first
   always_ff @(posedge vga_clk)
   begin
      if (rst)
         shift_q <= '0;
      else if (load_pix)
         shift_q <= slot_load ? glyph : 8'h00;  // border slots blank
      else if (~mode.double_wide | ~pos.pix[0])
         shift_q <= {shift_q[6:0], 1'b0};       // half rate when double wide
   end

   assign pixel_data = shift_q[7];

endmodule

`default_nettype wire

//--- src/vdg_top.sv
`timescale 1ns/1ps
`default_nettype none

module vdg_top #(
   parameter int DSP_DEPTH = 2048,
   parameter int CG_DEPTH  = 4096
) (
   input  wire logic                vga_clk,
   input  wire logic                rst,
   input  wire logic                awvalid,
   output logic                     awready,
   input  wire vdg_pkg::axil_addr_t awaddr,
   input  wire logic                wvalid,
   output logic                     wready,
   input  wire vdg_pkg::axil_data_t wdata,
   input  wire logic [3:0]          wstrb,
   output logic                     bvalid,
   input  wire logic                bready,
   output logic [1:0]               bresp,
   input  wire logic                arvalid,
   output logic                     arready,
   input  wire vdg_pkg::axil_addr_t araddr,
   output logic                     rvalid,
   input  wire logic                rready,
   output vdg_pkg::axil_data_t      rdata,
   output logic [1:0]               rresp,
   output logic                     h_sync,
   output logic                     v_sync,
   output logic                     pixel_data,
   output logic                     is_80col,
   output logic                     is_doublwide
);
   import vdg_pkg::*;

   mode_reg_t   mode;
   raster_pos_t pos;
   logic        active;
   logic        dsp_en, dsp_we, cg_en, cg_we;
   dsp_addr_t   dsp_host_idx, dsp_vid_idx;
   cg_addr_t    cg_host_idx, cg_vid_idx;
   char_code_t  dsp_wdata, dsp_host_rdata, dsp_vid_data;
   char_code_t  cg_wdata, cg_vid_data;

   vdg_host_regs host_regs_inst (
      .vga_clk, .rst,
      .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata, .wstrb,
      .bvalid, .bready, .bresp,
      .arvalid, .arready, .araddr, .rvalid, .rready, .rdata, .rresp,
      .mode,
      .dsp_en, .dsp_we, .dsp_idx(dsp_host_idx), .dsp_wdata, .dsp_rdata(dsp_host_rdata),
      .cg_en, .cg_we, .cg_idx(cg_host_idx), .cg_wdata
   );

   vdg_raster_timing raster_timing_inst (
      .vga_clk, .rst, .mode, .pos, .active, .h_sync, .v_sync
   );

   vdg_char_pipeline char_pipeline_inst (
      .vga_clk, .rst, .pos, .active, .mode,
      .dsp_idx(dsp_vid_idx), .dsp_data(dsp_vid_data),
      .cg_idx(cg_vid_idx), .cg_data(cg_vid_data),
      .pixel_data
   );

   // display RAM, video port reads every cycle
   vdg_dual_port_ram #(.DEPTH(DSP_DEPTH), .ADDR_W($clog2(DSP_DEPTH))) dsp_ram_inst (
      .vga_clk,
      .a_en(dsp_en), .a_we(dsp_we), .a_idx(dsp_host_idx), .a_wdata(dsp_wdata),
      .a_rdata(dsp_host_rdata),
      .b_en(1'b1), .b_idx(dsp_vid_idx), .b_rdata(dsp_vid_data)
   );

   // character generator, host readback not wired
   vdg_dual_port_ram #(.DEPTH(CG_DEPTH), .ADDR_W($clog2(CG_DEPTH))) cg_ram_inst (
      .vga_clk,
      .a_en(cg_en), .a_we(cg_we), .a_idx(cg_host_idx), .a_wdata(cg_wdata),
      .a_rdata(),
      .b_en(1'b1), .b_idx(cg_vid_idx), .b_rdata(cg_vid_data)
   );

   assign is_80col     = pos.cols80;       // follows the frame latch
   assign is_doublwide = mode.double_wide;

endmodule

`default_nettype wire

//--- dv/vdg_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module vdg_clk_gen #(
   parameter int HALF_NS = 10  // 20 ns period
) (
   output logic vga_clk
);

   initial
   begin
      vga_clk = 1'b0;
      forever #(HALF_NS) vga_clk = ~vga_clk;
   end

endmodule

`default_nettype wire

//--- dv/vdg_tb.sv
`timescale 1ns/1ps
`default_nettype none

module vdg_tb;
   import vdg_pkg::*;

   localparam int LINE_CYC    = 800;
   localparam int FRAME_CYC   = 420000;
   localparam int PIX_LAT     = 146;               // h_sync rise to slot 0 pixel 0
   localparam int LINE_START  = PIX_LAT - 5;       // slot 0 shows from pixel 5
   localparam int VSYNC_LINE  = 489;               // vsync row, line 9, both modes
   localparam int FRAME_HLINE = 525 - VSYNC_LINE;  // h_sync rises from v_sync to line 0
   localparam int WDOG_CYC    = 4 * FRAME_CYC + 4000;  // frames plus AXI traffic

   logic vga_clk, rst;
   logic awvalid, awready, wvalid, wready, bvalid, bready;
   logic arvalid, arready, rvalid, rready;
   axil_addr_t awaddr, araddr;
   axil_data_t wdata, rdata, exp_rdata;
   logic [3:0] wstrb;
   logic [1:0] bresp, rresp;
   logic h_sync, v_sync, pixel_data, is_80col, is_doublwide;

   logic hs_d, vs_d, hs_seen, vs_seen;
   int   hs_cnt, hs_hi, vs_cnt, vs_hi, hline;  // hline counts h_sync rises after v_sync
   logic want_80, lat_80;        // expected frame-latched cols80
   logic wr_is_mode;
   logic [7:0] wr_byte;
   logic chk_on, pix_chk, exp_pixel;
   int   chk_line, tgt_slot;
   logic [7:0] tgt_glyph, glyph, blk_pat;
   logic [31:0] rnd;

   vdg_clk_gen clk_gen_inst (.vga_clk(vga_clk));

   vdg_top vdg_top_inst (
      .vga_clk(vga_clk), .rst(rst),
      .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
      .wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
      .bvalid(bvalid), .bready(bready), .bresp(bresp),
      .arvalid(arvalid), .arready(arready), .araddr(araddr),
      .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
      .h_sync(h_sync), .v_sync(v_sync), .pixel_data(pixel_data),
      .is_80col(is_80col), .is_doublwide(is_doublwide)
   );

   task automatic compare_fail(input string name, input int exp_v, input int got_v);
      $display("Mismatch at %0t ns: %s expected %0h got %0h", $time, name, exp_v, got_v);
      $display("STATUS: FAIL");
      $fatal(1);
   endtask

   // bit of a character row, msb first, for the cycle n after h_sync rise
   function automatic logic glyph_bit(input int n, input int slot, input logic [7:0] g);
      int rel;
      rel = n - PIX_LAT - 8 * slot;
      if (rel >= 0 && rel < 8)
         return g[7 - rel];
      return 1'b0;
   endfunction

   assign exp_pixel = glyph_bit(hs_cnt, tgt_slot, tgt_glyph);
   assign pix_chk   = chk_on && (hline == chk_line || hline == chk_line + 1) &&
                      (hs_cnt >= PIX_LAT) && (hs_cnt < PIX_LAT + 640);

   // raster bookkeeping from the sync outputs
   always @(posedge vga_clk)
   begin
      if (rst)
      begin
         hs_d    <= 1'b0;
         vs_d    <= 1'b0;
         hs_seen <= 1'b0;
         vs_seen <= 1'b0;
         hs_cnt  <= 0;
         hs_hi   <= 0;
         vs_cnt  <= 0;
         vs_hi   <= 0;
         hline   <= 0;
         lat_80  <= 1'b0;
      end
      else
      begin
         hs_d  <= h_sync;
         vs_d  <= v_sync;
         hs_hi <= h_sync ? hs_hi + 1 : 0;
         vs_hi <= v_sync ? vs_hi + 1 : 0;
         hs_cnt <= (h_sync && !hs_d) ? 1 : hs_cnt + 1;
         vs_cnt <= (v_sync && !vs_d) ? 1 : vs_cnt + 1;
         if (h_sync && !hs_d)
            hs_seen <= 1'b1;
         if (v_sync && !vs_d)
            vs_seen <= 1'b1;
         if (v_sync && !vs_d)
            hline <= 0;
         else if (h_sync && !hs_d)
            hline <= hline + 1;
         if (hline == FRAME_HLINE && hs_cnt == LINE_START)  // line 0, pixel 0
            lat_80 <= want_80;
      end
   end

   assert property (@(posedge vga_clk) disable iff (rst)
      $rose(h_sync) && hs_seen |-> hs_cnt == LINE_CYC)
      else compare_fail("h_sync period", LINE_CYC, $sampled(hs_cnt));
   assert property (@(posedge vga_clk) disable iff (rst) $fell(h_sync) |-> hs_hi == 96)
      else compare_fail("h_sync width", 96, $sampled(hs_hi));
   assert property (@(posedge vga_clk) disable iff (rst)
      $rose(v_sync) && vs_seen |-> vs_cnt == FRAME_CYC)
      else compare_fail("v_sync period", FRAME_CYC, $sampled(vs_cnt));
   assert property (@(posedge vga_clk) disable iff (rst) $fell(v_sync) |-> vs_hi == 1600)
      else compare_fail("v_sync width", 1600, $sampled(vs_hi));
   assert property (@(posedge vga_clk) disable iff (rst) bvalid |-> bresp == 2'b00)
      else compare_fail("bresp", 0, $sampled(bresp));
   assert property (@(posedge vga_clk) disable iff (rst) rvalid |-> rresp == 2'b00)
      else compare_fail("rresp", 0, $sampled(rresp));
   assert property (@(posedge vga_clk) disable iff (rst) rvalid && rready |-> rdata == exp_rdata)
      else compare_fail("rdata", $sampled(exp_rdata), $sampled(rdata));
   assert property (@(posedge vga_clk) disable iff (rst)
      rvalid && !rready |=> rvalid && $stable(rdata))
      else compare_fail("rvalid held", 1, $sampled(rvalid));
   assert property (@(posedge vga_clk) disable iff (rst)
      $rose(bvalid) && wr_is_mode |-> is_doublwide == wr_byte[2])
      else compare_fail("is_doublwide", $sampled(wr_byte[2]), $sampled(is_doublwide));
   assert property (@(posedge vga_clk) disable iff (rst)
      $changed(is_80col) |-> hline == FRAME_HLINE && hs_cnt == LINE_START)
      else compare_fail("is_80col change point", LINE_START, $sampled(hs_cnt));
   assert property (@(posedge vga_clk) disable iff (rst) $rose(v_sync) |-> is_80col == lat_80)
      else compare_fail("is_80col", $sampled(lat_80), $sampled(is_80col));
   assert property (@(posedge vga_clk) disable iff (rst) pix_chk |-> pixel_data == exp_pixel)
      else compare_fail("pixel_data", $sampled(exp_pixel), $sampled(pixel_data));

   task automatic axi_write(input axil_addr_t addr, input logic [7:0] data);
      @(posedge vga_clk);
      wr_is_mode <= (addr[15:14] == REGION_MODE);
      wr_byte    <= data;
      awaddr     <= addr;
      wdata      <= {24'd0, data};
      wstrb      <= 4'h1;
      awvalid    <= 1'b1;
      wvalid     <= 1'b1;
      @(posedge vga_clk);
      while (!(awready && wready))
         @(posedge vga_clk);
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      @(posedge vga_clk);
      while (!bvalid)  // bready is always high
         @(posedge vga_clk);
   endtask

   task automatic axi_read(input axil_addr_t addr, input axil_data_t expect_v);
      @(posedge vga_clk);
      exp_rdata <= expect_v;
      araddr    <= addr;
      arvalid   <= 1'b1;
      @(posedge vga_clk);
      while (!arready)
         @(posedge vga_clk);
      arvalid <= 1'b0;
      @(posedge vga_clk);
      while (!rvalid)
         @(posedge vga_clk);
      repeat (3) @(posedge vga_clk);  // back-pressure on rready
      rready <= 1'b1;
      @(posedge vga_clk);
      rready <= 1'b0;
   endtask

   function automatic axil_addr_t dsp_addr(input int idx);
      return {3'b000, 11'(idx), 2'b00};
   endfunction

   function automatic axil_addr_t cg_addr(input int idx);
      return {2'b01, 12'(idx), 2'b00};
   endfunction

   task automatic wait_vsync_rise();
      @(posedge vga_clk);
      while (!(v_sync && !vs_d))
         @(posedge vga_clk);
   endtask

   task automatic wait_hline(input int n);
      while (hline != n)
         @(posedge vga_clk);
   endtask

   // watchdog
   initial
   begin
      #(WDOG_CYC * 20);
      $display("timeout, the test sequence did not finish in time");
      $display("STATUS: FAIL");
      $fatal(1);
   end

   initial
   begin
      void'($urandom(32'h40544e90));
      rst        = 1'b1;
      awvalid    = 1'b0;
      awaddr     = '0;
      wvalid     = 1'b0;
      wdata      = '0;
      wstrb      = '0;
      bready     = 1'b1;
      arvalid    = 1'b0;
      araddr     = '0;
      rready     = 1'b0;
      exp_rdata  = '0;
      wr_is_mode = 1'b0;
      wr_byte    = '0;
      want_80    = 1'b0;
      chk_on     = 1'b0;
      chk_line   = 0;
      tgt_slot   = 0;
      tgt_glyph  = '0;
      repeat (10) @(posedge vga_clk);
      rst <= 1'b0;
      rnd = $urandom;
      glyph   = rnd[7:0];
      blk_pat = {2'b00, rnd[13:8]};
      // register and RAM readback
      axi_write(16'h8000, 8'h0A);
      axi_read(16'h8000, 32'h0000_000A);
      axi_write(dsp_addr(5), rnd[23:16]);
      axi_read(dsp_addr(5), {24'd0, rnd[23:16]});
      // blank code 0, glyph for code 0x41 row 0
      axi_write(cg_addr(0), 8'h00);
      axi_write(cg_addr(16'h41 * 16), glyph);
      for (int i = 0; i < 192; i++)
         axi_write(dsp_addr(i), 8'h00);
      axi_write(dsp_addr(0), 8'h41);           // row 2, plain
      axi_write(dsp_addr(64), 8'hC1);          // row 3, inverse
      axi_write(dsp_addr(128), 8'h80 | blk_pat);  // row 4, block graphic
      axi_write(16'h8000, 8'h00);              // 64x16, inverse off
      wait_vsync_rise();
      chk_on    <= 1'b1;
      chk_line  <= 84;
      tgt_slot  <= 8;
      tgt_glyph <= glyph;
      wait_hline(86);
      axi_write(16'h8000, 8'h02);              // inverse on for row 3
      chk_line  <= 108;
      tgt_glyph <= ~glyph;
      wait_hline(110);
      axi_write(16'h8000, 8'h00);              // inverse off for block graphic
      chk_line  <= 132;
      tgt_glyph <= {{4{blk_pat[0]}}, {4{blk_pat[1]}}};
      wait_hline(134);
      chk_on <= 1'b0;
      // switch to 80x24 right after v_sync, latched at frame start
      wait_vsync_rise();
      axi_write(dsp_addr(64), 8'h00);
      want_80 <= 1'b1;
      axi_write(16'h8000, 8'h01);
      chk_on    <= 1'b1;
      chk_line  <= FRAME_HLINE;
      tgt_slot  <= 0;
      tgt_glyph <= glyph;
      wait_hline(FRAME_HLINE + 2);
      chk_on <= 1'b0;
      wait_vsync_rise();
      axi_write(16'h8000, 8'h05);              // double wide
      repeat (4) @(posedge vga_clk);
      $display("STATUS: PASS");
      $finish;
   end

endmodule

`default_nettype wire

//--- files.f
src/vdg_pkg.sv
src/vdg_host_regs.sv
src/vdg_raster_timing.sv
src/vdg_dual_port_ram.sv
src/vdg_char_pipeline.sv
src/vdg_top.sv
dv/vdg_clk_gen.sv
dv/vdg_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the VDG testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module vdg_tb \
   -f files.f --Mdir obj_dir -o vdg_sim
if [ $? -ne 0 ]; then
   echo "verilator compile failed"
   exit 1
fi

./obj_dir/vdg_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if grep -qx "STATUS: PASS" sim.log; then
   exit 0
fi
echo "pass message not found in sim.log"
exit 1
